// File: common/cache_pkg.sv
package cache_pkg;

    // cache geometry
    localparam int NUM_LINES      = 256;
    localparam int WORDS_PER_LINE = 4;

    // main memory has one bank per word of a line
    localparam int NUM_BANKS        = 4;
    localparam int MEM_BANK_DEPTH   = 8192;
    localparam int MEM_READ_LATENCY = 2;   // mem_read to valid data_out

    typedef logic [15:0] data_t;
    typedef logic [15:0] addr_t;
    typedef logic [4:0]  tag_t;
    typedef logic [7:0]  idx_t;
    typedef logic [2:0]  offset_t;
    typedef logic [1:0]  word_sel_t;    // word in a line and also the bank number
    typedef logic [12:0] bank_addr_t;   // word address inside one bank

    typedef enum logic [3:0] {
        IDLE,
        COMP_RD,
        COMP_WR,
        WB_0,
        WB_1,
        WB_2,
        WB_3,
        FILL_0,
        FILL_1,
        FILL_2,
        FILL_3,
        FILL_4,
        FILL_5
    } cntrl_state_t;

endpackage

// File: cache/cache_way.sv
`timescale 1ns/1ps

module cache_way (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic               comp,
    input  logic               write,
    input  logic               valid_in,
    input  cache_pkg::tag_t    tag,
    input  cache_pkg::idx_t    idx,
    input  cache_pkg::offset_t offset,
    input  cache_pkg::data_t   data_in,
    output logic               hit,
    output logic               valid,
    output logic               dirty,
    output cache_pkg::tag_t    tag_out,
    output cache_pkg::data_t   data_out
);

    logic [cache_pkg::NUM_LINES-1:0] valid_q;
    logic [cache_pkg::NUM_LINES-1:0] dirty_q;

    cache_pkg::tag_t  tag_mem  [cache_pkg::NUM_LINES];
    cache_pkg::data_t data_mem [cache_pkg::NUM_LINES][cache_pkg::WORDS_PER_LINE];

    cache_pkg::word_sel_t word;
    logic                 wr_hit;
    logic                 wr_fill;

    assign word = offset[2:1];   // callers only use even byte offsets

    assign valid    = valid_q[idx];
    assign dirty    = dirty_q[idx];
    assign tag_out  = tag_mem[idx];
    assign data_out = data_mem[idx][word];
    assign hit      = valid & (tag_out == tag);

    assign wr_hit  = en & write & comp & hit;   // cpu write into a resident line
    assign wr_fill = en & write & ~comp;        // line fill from memory

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_hit) begin
            dirty_q[idx] <= 1'b1;
        end else if (wr_fill) begin
            valid_q[idx] <= valid_in;
            dirty_q[idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hit || wr_fill) begin
            data_mem[idx][word] <= data_in;
        end
        if (wr_fill) begin
            tag_mem[idx] <= tag;
        end
    end

endmodule

// File: cache/way_select.sv
`timescale 1ns/1ps

module way_select (
    input  logic             clk,
    input  logic             rst,
    input  logic             sel_way,
    input  logic             flip_victim,
    input  logic             dirty_0,
    input  logic             dirty_1,
    input  cache_pkg::tag_t  tag_0,
    input  cache_pkg::tag_t  tag_1,
    input  cache_pkg::data_t data_0,
    input  cache_pkg::data_t data_1,
    output logic             victim,
    output logic             dirty_sel,
    output cache_pkg::tag_t  tag_sel,
    output cache_pkg::data_t data_sel
);

    // single bit replacement that flips once per completed fill
    always_ff @(posedge clk) begin
        if (rst) begin
            victim <= 1'b0;
        end else if (flip_victim) begin
            victim <= ~victim;
        end
    end

    // sel_way is the hitting way at lookup and the chosen way during a miss
    assign dirty_sel = sel_way ? dirty_1 : dirty_0;
    assign tag_sel   = sel_way ? tag_1   : tag_0;
    assign data_sel  = sel_way ? data_1  : data_0;

endmodule

// File: cache/cache_cntrl_assoc.sv
`timescale 1ns/1ps

module cache_cntrl_assoc (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd,
    input  logic              wr,
    input  cache_pkg::addr_t  addr,
    input  cache_pkg::data_t  data_in,
    input  logic              hit_0,
    input  logic              hit_1,
    input  logic              valid_0,
    input  logic              valid_1,
    input  logic              victim,
    input  logic              dirty_sel,
    input  cache_pkg::tag_t   tag_sel,
    input  cache_pkg::data_t  data_sel,
    input  cache_pkg::data_t  mem_data_out,
    output logic              en_0,
    output logic              en_1,
    output logic              comp,
    output logic              write,
    output logic              valid_in,
    output cache_pkg::tag_t   tag,
    output cache_pkg::idx_t   idx,
    output cache_pkg::offset_t offset,
    output cache_pkg::data_t  cache_data_in,
    output logic              sel_way,
    output logic              flip_victim,
    output cache_pkg::addr_t  mem_addr,
    output cache_pkg::data_t  mem_data_in,
    output logic              mem_write,
    output logic              mem_read,
    output cache_pkg::data_t  data_out,
    output logic              done,
    output logic              stall,
    output logic              cache_hit
);

    cache_pkg::cntrl_state_t state;
    cache_pkg::cntrl_state_t nxt_state;

    logic                 way_q;         // way picked at the COMP cycle
    logic                 way_choice;
    logic                 valid_choice;
    logic                 hit_any;
    logic                 fill_rd;
    logic                 fill_wr;
    logic [3:0]           wb_pos;
    logic [3:0]           fill_pos;
    cache_pkg::word_sel_t req_word;
    cache_pkg::word_sel_t wb_word;
    cache_pkg::word_sel_t rd_word;
    cache_pkg::word_sel_t wr_word;
    cache_pkg::data_t     data_temp;

    assign hit_any  = hit_0 | hit_1;
    assign req_word = addr[2:1];

    // word numbers follow directly from the position inside the WB and FILL runs
    assign wb_pos   = state - cache_pkg::WB_0;
    assign fill_pos = state - cache_pkg::FILL_0;
    assign wb_word  = wb_pos[1:0];
    assign rd_word  = fill_pos[1:0];
    assign wr_word  = fill_pos[1:0] - 2'd2;   // fill data lags the read by two cycles

    assign fill_rd = (state == cache_pkg::FILL_0) || (state == cache_pkg::FILL_1) ||
                     (state == cache_pkg::FILL_2) || (state == cache_pkg::FILL_3);
    assign fill_wr = (state == cache_pkg::FILL_2) || (state == cache_pkg::FILL_3) ||
                     (state == cache_pkg::FILL_4) || (state == cache_pkg::FILL_5);

    // hitting way first, then an empty way, then the victim
    always_comb begin
        if (hit_any) begin
            way_choice = hit_1;
        end else if (!valid_0) begin
            way_choice = 1'b0;
        end else if (!valid_1) begin
            way_choice = 1'b1;
        end else begin
            way_choice = victim;
        end
    end

    assign valid_choice = way_choice ? valid_1 : valid_0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::IDLE;
            way_q <= 1'b0;
        end else begin
            state <= nxt_state;
            if (state == cache_pkg::COMP_RD || state == cache_pkg::COMP_WR) begin
                way_q <= way_choice;
            end
        end
    end

    // keeps the requested word once it has gone past on the memory bus
    always_ff @(posedge clk) begin
        if (fill_wr && wr_word == req_word) begin
            data_temp <= mem_data_out;
        end
    end

    always_comb begin
        nxt_state     = state;
        en_0          = 1'b0;
        en_1          = 1'b0;
        comp          = 1'b0;
        write         = 1'b0;
        valid_in      = 1'b0;
        tag           = addr[15:11];
        idx           = addr[10:3];
        offset        = addr[2:0];
        cache_data_in = data_in;
        sel_way       = way_q;
        flip_victim   = 1'b0;
        mem_addr      = '0;
        mem_data_in   = data_sel;
        mem_write     = 1'b0;
        mem_read      = 1'b0;
        data_out      = data_temp;
        done          = 1'b0;
        stall         = 1'b1;
        cache_hit     = 1'b0;

        case (state)
            cache_pkg::IDLE: begin
                stall = 1'b0;
                if (rd) begin
                    nxt_state = cache_pkg::COMP_RD;
                end else if (wr) begin
                    nxt_state = cache_pkg::COMP_WR;
                end
            end
            cache_pkg::COMP_RD, cache_pkg::COMP_WR: begin
                en_0      = 1'b1;
                en_1      = 1'b1;
                comp      = 1'b1;
                write     = (state == cache_pkg::COMP_WR);
                sel_way   = way_choice;   // on a miss this exposes the victim's dirty bit
                data_out  = data_sel;
                done      = hit_any;
                cache_hit = hit_any;
                if (hit_any) begin
                    nxt_state = cache_pkg::IDLE;
                end else if (valid_choice && dirty_sel) begin
                    nxt_state = cache_pkg::WB_0;
                end else begin
                    nxt_state = cache_pkg::FILL_0;
                end
            end
            cache_pkg::WB_0, cache_pkg::WB_1, cache_pkg::WB_2, cache_pkg::WB_3: begin
                offset    = {wb_word, 1'b0};
                mem_addr  = {tag_sel, addr[10:3], wb_word, 1'b0};
                mem_write = 1'b1;
                nxt_state = cache_pkg::cntrl_state_t'(state + 4'd1);   // WB_3 runs into FILL_0
            end
            cache_pkg::FILL_0, cache_pkg::FILL_1, cache_pkg::FILL_2,
            cache_pkg::FILL_3, cache_pkg::FILL_4, cache_pkg::FILL_5: begin
                if (fill_rd) begin
                    mem_read = 1'b1;
                    mem_addr = {addr[15:3], rd_word, 1'b0};
                end
                if (fill_wr) begin
                    en_0     = ~way_q;
                    en_1     = way_q;
                    write    = 1'b1;
                    valid_in = 1'b1;
                    offset   = {wr_word, 1'b0};
                    cache_data_in = (wr && wr_word == req_word) ? data_in : mem_data_out;
                    data_out      = (rd && wr_word == req_word) ? mem_data_out : data_temp;
                end
                if (state == cache_pkg::FILL_5) begin
                    // the tag is already in place, so a write hits here and marks the line dirty
                    comp        = wr;
                    flip_victim = 1'b1;
                    done        = 1'b1;
                    nxt_state   = cache_pkg::IDLE;
                end else begin
                    nxt_state = cache_pkg::cntrl_state_t'(state + 4'd1);
                end
            end
            default: begin
                nxt_state = cache_pkg::IDLE;
            end
        endcase
    end

endmodule

// File: verilog/mem_banked.sv
`timescale 1ns/1ps

module mem_banked (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t addr,
    input  cache_pkg::data_t data_in,
    input  logic             write,
    input  logic             read,
    output cache_pkg::data_t data_out
);

    cache_pkg::word_sel_t  bank_sel;
    cache_pkg::word_sel_t  rd_bank_q;
    cache_pkg::bank_addr_t bank_word;
    cache_pkg::data_t      bank_rd [cache_pkg::NUM_BANKS];
    cache_pkg::data_t      data_q;

    logic [cache_pkg::MEM_READ_LATENCY-1:0] rd_vld_q;

    // consecutive words of a line land in consecutive banks
    assign bank_sel  = addr[2:1];
    assign bank_word = addr[15:3];

    for (genvar b = 0; b < cache_pkg::NUM_BANKS; b++) begin : g_bank
        cache_pkg::data_t bank_mem [cache_pkg::MEM_BANK_DEPTH];
        cache_pkg::data_t rd_q;

        initial begin
            for (int i = 0; i < cache_pkg::MEM_BANK_DEPTH; i++) begin
                bank_mem[i] = '0;
            end
        end

        // first read stage is the bank's own synchronous read
        always_ff @(posedge clk) begin
            if (write && bank_sel == cache_pkg::word_sel_t'(b)) begin
                bank_mem[bank_word] <= data_in;
            end
            if (read && bank_sel == cache_pkg::word_sel_t'(b)) begin
                rd_q <= bank_mem[bank_word];
            end
        end

        assign bank_rd[b] = rd_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld_q <= '0;
        end else begin
            rd_vld_q <= {rd_vld_q[cache_pkg::MEM_READ_LATENCY-2:0], read};
        end
    end

    // second stage picks the bank that served the read one cycle earlier
    always_ff @(posedge clk) begin
        if (read) begin
            rd_bank_q <= bank_sel;
        end
        if (rd_vld_q[0]) begin
            data_q <= bank_rd[rd_bank_q];
        end
    end

    assign data_out = rd_vld_q[cache_pkg::MEM_READ_LATENCY-1] ? data_q : '0;

endmodule

// File: verilog/mem_system_assoc.sv
`timescale 1ns/1ps

module mem_system_assoc (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t addr,
    input  cache_pkg::data_t data_in,
    input  logic             rd,
    input  logic             wr,
    output cache_pkg::data_t data_out,
    output logic             done,
    output logic             stall,
    output logic             cache_hit
);

    logic               en_0, en_1, comp, write, valid_in;
    logic               hit_0, hit_1, valid_0, valid_1, dirty_0, dirty_1;
    logic               sel_way, flip_victim, victim, dirty_sel;
    logic               mem_write, mem_read;
    cache_pkg::tag_t    tag, tag_0, tag_1, tag_sel;
    cache_pkg::idx_t    idx;
    cache_pkg::offset_t offset;
    cache_pkg::data_t   cache_data_in, data_0, data_1, data_sel;
    cache_pkg::addr_t   mem_addr;
    cache_pkg::data_t   mem_data_in, mem_data_out;

    cache_cntrl_assoc u_cntrl (
        .clk(clk), .rst(rst), .rd(rd), .wr(wr), .addr(addr), .data_in(data_in),
        .hit_0(hit_0), .hit_1(hit_1), .valid_0(valid_0), .valid_1(valid_1),
        .victim(victim), .dirty_sel(dirty_sel), .tag_sel(tag_sel), .data_sel(data_sel),
        .mem_data_out(mem_data_out),
        .en_0(en_0), .en_1(en_1), .comp(comp), .write(write), .valid_in(valid_in),
        .tag(tag), .idx(idx), .offset(offset), .cache_data_in(cache_data_in),
        .sel_way(sel_way), .flip_victim(flip_victim),
        .mem_addr(mem_addr), .mem_data_in(mem_data_in), .mem_write(mem_write),
        .mem_read(mem_read), .data_out(data_out), .done(done), .stall(stall),
        .cache_hit(cache_hit)
    );

    cache_way u_way_0 (
        .clk(clk), .rst(rst), .en(en_0), .comp(comp), .write(write), .valid_in(valid_in),
        .tag(tag), .idx(idx), .offset(offset), .data_in(cache_data_in),
        .hit(hit_0), .valid(valid_0), .dirty(dirty_0), .tag_out(tag_0), .data_out(data_0)
    );

    cache_way u_way_1 (
        .clk(clk), .rst(rst), .en(en_1), .comp(comp), .write(write), .valid_in(valid_in),
        .tag(tag), .idx(idx), .offset(offset), .data_in(cache_data_in),
        .hit(hit_1), .valid(valid_1), .dirty(dirty_1), .tag_out(tag_1), .data_out(data_1)
    );

    way_select u_sel (
        .clk(clk), .rst(rst), .sel_way(sel_way), .flip_victim(flip_victim),
        .dirty_0(dirty_0), .dirty_1(dirty_1), .tag_0(tag_0), .tag_1(tag_1),
        .data_0(data_0), .data_1(data_1),
        .victim(victim), .dirty_sel(dirty_sel), .tag_sel(tag_sel), .data_sel(data_sel)
    );

    mem_banked u_mem (
        .clk(clk), .rst(rst), .addr(mem_addr), .data_in(mem_data_in),
        .write(mem_write), .read(mem_read), .data_out(mem_data_out)
    );

endmodule

// File: test/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    // reset is high for four rising edges and drops just after the last one
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: test/mem_system_checker.sv
`timescale 1ns/1ps

module mem_system_checker (
    input logic clk,
    input logic rst,
    input logic done,
    input logic stall,
    input logic mem_read,
    input logic mem_write
);

    int fail_count = 0;   // watched by the testbench at every falling edge

    // each request ends with a single one-cycle done
    done_single_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done was high in two consecutive cycles");
            fail_count++;
        end

    // the memory port carries one word operation per cycle
    mem_port_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write were high together");
            fail_count++;
        end

    stall_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !stall)
        else begin
            $error("stall was high in the first cycle after reset");
            fail_count++;
        end

endmodule

bind mem_system_assoc mem_system_checker u_checker (
    .clk(clk),
    .rst(rst),
    .done(done),
    .stall(stall),
    .mem_read(mem_read),
    .mem_write(mem_write)
);

// File: test/tb_mem_system.sv
`timescale 1ns/1ps

module tb_mem_system;

    typedef struct packed {
        logic             is_wr;
        cache_pkg::addr_t addr;
        cache_pkg::data_t wdata;
        logic             exp_hit;
        cache_pkg::data_t exp_rdata;
        logic [3:0]       exp_lat;     // cycles from the accepting edge to done
    } entry_t;

    logic             clk;
    logic             rst;
    logic             rd;
    logic             wr;
    cache_pkg::addr_t addr;
    cache_pkg::data_t data_in;
    cache_pkg::data_t data_out;
    logic             done;
    logic             stall;
    logic             cache_hit;

    entry_t entry_tbl[$];
    string  entry_name[$];

    clock_gen u_clock_gen (
        .clk(clk),
        .rst(rst)
    );

    mem_system_assoc u_dut (
        .clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
        .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit)
    );

    task automatic raise_error(string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, string what, logic [31:0] expected,
                               logic [31:0] actual);
        assert (actual === expected) else
            raise_error($sformatf("CHECK FAILED %s %s expected 0x%0h actual 0x%0h",
                                  name, what, expected, actual));
    endtask

    task automatic add_entry(string name, logic is_wr, cache_pkg::addr_t a,
                             cache_pkg::data_t wdata, logic exp_hit,
                             cache_pkg::data_t exp_rdata, int exp_lat);
        entry_t e;
        e.is_wr     = is_wr;
        e.addr      = a;
        e.wdata     = wdata;
        e.exp_hit   = exp_hit;
        e.exp_rdata = exp_rdata;
        e.exp_lat   = 4'(exp_lat);
        entry_tbl.push_back(e);
        entry_name.push_back(name);
    endtask

    // index 5 carries tags 1 to 5 while the victim bit starts at 0 and flips after each fill
    task automatic build_table();
        //         name                    wr    addr      wdata     hit   rdata     lat
        add_entry("cold_read",            1'b0, 16'h0008, 16'h0000, 1'b0, 16'h0000, 7);
        add_entry("cold_read_same_line",  1'b0, 16'h000A, 16'h0000, 1'b1, 16'h0000, 1);
        add_entry("write_miss",           1'b1, 16'h082A, 16'hA5C3, 1'b0, 16'h0000, 7);
        add_entry("read_back",            1'b0, 16'h082A, 16'h0000, 1'b1, 16'hA5C3, 1);
        add_entry("read_other_word",      1'b0, 16'h082E, 16'h0000, 1'b1, 16'h0000, 1);
        add_entry("write_hit",            1'b1, 16'h0828, 16'h1234, 1'b1, 16'h0000, 1);
        add_entry("second_way",           1'b0, 16'h102C, 16'h0000, 1'b0, 16'h0000, 7);
        add_entry("first_line_kept",      1'b0, 16'h082A, 16'h0000, 1'b1, 16'hA5C3, 1);
        add_entry("dirty_way_1",          1'b1, 16'h1028, 16'h5A5A, 1'b1, 16'h0000, 1);
        add_entry("third_tag_evict",      1'b0, 16'h182E, 16'h0000, 1'b0, 16'h0000, 11);
        add_entry("evicted_word",         1'b0, 16'h1028, 16'h0000, 1'b0, 16'h5A5A, 11);
        add_entry("tag1_reload",          1'b0, 16'h082A, 16'h0000, 1'b0, 16'hA5C3, 7);
        add_entry("tag1_word0",           1'b0, 16'h0828, 16'h0000, 1'b1, 16'h1234, 1);
        add_entry("write_miss_last_word", 1'b1, 16'h182E, 16'hBEEF, 1'b0, 16'h0000, 7);
        add_entry("read_last_word",       1'b0, 16'h182E, 16'h0000, 1'b1, 16'hBEEF, 1);
        add_entry("tag4_fill",            1'b0, 16'h2028, 16'h0000, 1'b0, 16'h0000, 7);
        add_entry("tag5_evict",           1'b0, 16'h282C, 16'h0000, 1'b0, 16'h0000, 11);
        add_entry("tag3_reload",          1'b0, 16'h182E, 16'h0000, 1'b0, 16'hBEEF, 7);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 10) begin
                raise_error("reset was never released");
            end
        end
    endtask

    task automatic check_idle(int num_cycles);
        for (int i = 0; i < num_cycles; i++) begin
            @(negedge clk);
            assert (!done && !stall) else
                raise_error("done or stall was high with no request pending");
        end
    endtask

    task automatic apply_entry(int n);
        entry_t e;
        string  name;
        int     cycles;
        bit     got_done;
        e        = entry_tbl[n];
        name     = entry_name[n];
        cycles   = 0;
        got_done = 1'b0;

        @(posedge clk);
        #1;
        rd      = ~e.is_wr;
        wr      = e.is_wr;
        addr    = e.addr;
        data_in = e.wdata;

        @(negedge clk);
        assert (!stall && !done) else
            raise_error($sformatf("%s found the controller busy before the request", name));

        // the request stays on the inputs until done shows up
        while (!got_done) begin
            @(negedge clk);
            cycles++;
            assert (stall) else
                raise_error($sformatf("%s saw stall drop before done", name));
            if (done) begin
                got_done = 1'b1;
                check_value(name, "cache_hit", 32'(e.exp_hit), 32'(cache_hit));
                if (!e.is_wr) begin
                    check_value(name, "data_out", 32'(e.exp_rdata), 32'(data_out));
                end
                check_value(name, "latency", 32'(e.exp_lat), cycles);
            end else if (cycles >= 20) begin   // a dirty miss needs 11
                raise_error($sformatf("%s timed out because done never arrived", name));
            end
        end

        @(posedge clk);
        #1;
        rd = 1'b0;
        wr = 1'b0;
        @(negedge clk);
        assert (!done && !stall) else
            raise_error($sformatf("%s was taken a second time after its done", name));
    endtask

    // picks up failures of the bound protocol assertions
    always @(negedge clk) begin
        assert (u_dut.u_checker.fail_count == 0) else
            raise_error("a protocol assertion on the top level failed");
    end

    initial begin
        rd      = 1'b0;
        wr      = 1'b0;
        addr    = '0;
        data_in = '0;
        build_table();
        wait_reset_release();
        check_idle(3);
        for (int n = 0; n < entry_tbl.size(); n++) begin
            apply_entry(n);
        end
        check_idle(3);   // no stray done once the table is finished
        $display("Regression passed");
        $finish;
    end

endmodule

// File: cache_assoc.f
common/cache_pkg.sv
cache/cache_way.sv
cache/way_select.sv
cache/cache_cntrl_assoc.sv
verilog/mem_banked.sv
verilog/mem_system_assoc.sv
test/clock_gen.sv
test/mem_system_checker.sv
test/tb_mem_system.sv

// File: run_sim.sh
#!/bin/sh
# builds the cache testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_system -f cache_assoc.f

# the error limit lets the testbench see a failed bound assertion and report it
sim_out=$(./obj_dir/Vtb_mem_system +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
